// File: common/aluPkg.sv
// ALU operation definitions
`default_nettype none

package aluPkg;

    // Datapath word width
    localparam int DataWidth = 32;

    // Operation encoding
    // Bits 3:2 pick the result source: arithmetic, logic, set-less-than, zero
    // Bit 1 inverts B and sets the carry-in, so subtraction is exact
    // Bits 1:0 pick the logic function
    typedef enum logic [3:0] {
        OpAdd  = 4'b0000, // A + B
        OpSub  = 4'b0010, // A - B
        OpAnd  = 4'b0100, // A & B
        OpOr   = 4'b0101, // A | B
        OpXor  = 4'b0110, // A ^ B
        OpNor  = 4'b0111, // ~(A | B)
        OpSlt  = 4'b1010, // Sign of A - B
        OpZero = 4'b1100  // Constant zero, used for no-ops
    } aluOpT;

endpackage

`default_nettype wire

// File: common/isaPkg.sv
// Instruction set definitions
`default_nettype none

package isaPkg;

    // Register index width, 32 registers
    localparam int RegAddrWidth = 5;

    // One instruction word, read either as R-type or as I-type
    typedef union packed {
        struct packed {
            logic [5:0] opcode;
            logic [4:0] rs;     // Source A
            logic [4:0] rt;     // Source B
            logic [4:0] rd;     // Destination
            logic [4:0] shamt;  // Unused, no shifts
            logic [5:0] funct;  // Operation
        } rFmt;
        struct packed {
            logic [5:0]  opcode;
            logic [4:0]  rs;    // Source A
            logic [4:0]  rt;    // Destination
            logic [15:0] imm;   // Immediate operand
        } iFmt;
    } instrT;

    // Opcodes
    localparam logic [5:0] OpcR    = 6'h00; // Register form, funct decides
    localparam logic [5:0] OpcAddi = 6'h08;
    localparam logic [5:0] OpcSlti = 6'h0A;
    localparam logic [5:0] OpcAndi = 6'h0C;
    localparam logic [5:0] OpcOri  = 6'h0D;
    localparam logic [5:0] OpcXori = 6'h0E;

    // Funct codes for OpcR
    localparam logic [5:0] FnAdd = 6'h20;
    localparam logic [5:0] FnSub = 6'h22;
    localparam logic [5:0] FnAnd = 6'h24;
    localparam logic [5:0] FnOr  = 6'h25;
    localparam logic [5:0] FnXor = 6'h26;
    localparam logic [5:0] FnNor = 6'h27;
    localparam logic [5:0] FnSlt = 6'h2A;

endpackage

`default_nettype wire

// File: common/pipeIfs.sv
// Pipeline stage interfaces
`timescale 1ns/10ps
`default_nettype none

// Decode to operand fetch
interface decIf import aluPkg::*, isaPkg::*; ();
    logic                    valid;    // Stage holds an item
    aluOpT                   aluOp;
    logic [RegAddrWidth-1:0] rs;       // Read index A
    logic [RegAddrWidth-1:0] rt;       // Read index B
    logic [RegAddrWidth-1:0] dest;     // Write index
    logic [15:0]             imm;      // Raw immediate
    logic                    useImm;   // B from immediate
    logic                    signExt;  // Immediate sign-extended
    logic                    writeEn;  // Result goes to register file

    modport src (output valid, aluOp, rs, rt, dest, imm, useImm, signExt, writeEn);
    modport dst (input  valid, aluOp, rs, rt, dest, imm, useImm, signExt, writeEn);
endinterface

// Operand fetch to execute
interface exIf import aluPkg::*, isaPkg::*; ();
    logic                    valid;    // Stage holds an item
    aluOpT                   aluOp;
    logic [DataWidth-1:0]    opA;      // Forwarded rs value
    logic [DataWidth-1:0]    opB;      // Forwarded rt value or immediate
    logic [RegAddrWidth-1:0] dest;
    logic                    writeEn;

    modport src (output valid, aluOp, opA, opB, dest, writeEn);
    modport dst (input  valid, aluOp, opA, opB, dest, writeEn);
endinterface

`default_nettype wire

// File: alu/alu.sv
// Integer ALU
`timescale 1ns/10ps
`default_nettype none

module alu import aluPkg::*; (
    input  aluOpT                aluOp,  // Operation select
    input  logic [DataWidth-1:0] a,      // Operand A
    input  logic [DataWidth-1:0] b,      // Operand B
    output logic [DataWidth-1:0] y,      // Selected result
    output logic                 zero    // High when y is all zeros
);

    logic                 subMode;  // Invert B plus carry-in
    logic [DataWidth-1:0] bSel;     // B or its complement
    logic [DataWidth-1:0] sum;      // Adder output
    logic [DataWidth-1:0] logicY;   // Logic unit output
    logic [DataWidth-1:0] sltY;     // Set-less-than word

    assign subMode = aluOp[1];
    assign bSel    = subMode ? ~b : b;

    // Two's complement subtract when subMode is set
    assign sum = a + bSel + {{(DataWidth - 1){1'b0}}, subMode};

    // Logic unit, low two bits pick the function
    always_comb begin
        case (aluOp[1:0])
            2'b00:   logicY = a & b;     // And
            2'b01:   logicY = a | b;     // Or
            2'b10:   logicY = a ^ b;     // Xor
            default: logicY = ~(a | b);  // Nor
        endcase
    end

    // Sign of the difference, no overflow correction
    assign sltY = {{(DataWidth - 1){1'b0}}, sum[DataWidth-1]};

    // Result source from the upper two bits
    always_comb begin
        case (aluOp[3:2])
            2'b00:   y = sum;     // Add or subtract
            2'b01:   y = logicY;  // Logic functions
            2'b10:   y = sltY;    // Set-less-than
            default: y = '0;      // No-op result
        endcase
    end

    assign zero = ~|y;  // Zero flag

endmodule

`default_nettype wire

// File: rtl/decodeStage.sv
// Input queue and instruction decode
`timescale 1ns/10ps
`default_nettype none

module decodeStage import aluPkg::*, isaPkg::*; #(
    parameter int InDepth = 4              // Queue depth, also producer credits
) (
    input  logic        clk,
    input  logic        rstN,
    input  logic        instrValid,        // Push from producer
    input  logic [31:0] instr,             // Pushed word
    input  logic        stall,             // Pipeline hold from execute
    output logic        instrCredit,       // One pulse per pop
    decIf.src           decOut
);

    localparam int PtrWidth = (InDepth > 1) ? $clog2(InDepth) : 1;
    localparam int CntWidth = $clog2(InDepth + 1);

    logic [31:0]             queue [InDepth];  // Word storage
    logic [PtrWidth-1:0]     wrPtr;
    logic [PtrWidth-1:0]     rdPtr;
    logic [CntWidth-1:0]     count;            // Words held
    logic                    pop;
    instrT                   head;             // Word at read pointer
    aluOpT                   opDec;
    logic [RegAddrWidth-1:0] rsDec;
    logic [RegAddrWidth-1:0] rtDec;
    logic [RegAddrWidth-1:0] destDec;
    logic                    useImmDec;
    logic                    signExtDec;
    logic                    writeEnDec;

    function automatic logic [PtrWidth-1:0] nextPtr(input logic [PtrWidth-1:0] ptr);
        return (ptr == PtrWidth'(InDepth - 1)) ? '0 : ptr + 1'b1;  // Wrap at depth
    endfunction

    assign pop  = (count != '0) && !stall;
    assign head = queue[rdPtr];

    always_ff @(posedge clk) begin
        if (!rstN) begin
            wrPtr       <= '0;
            rdPtr       <= '0;
            count       <= '0;
            instrCredit <= 1'b0;
        end else begin
            if (instrValid) wrPtr <= nextPtr(wrPtr);
            if (pop) rdPtr <= nextPtr(rdPtr);
            count       <= count + CntWidth'(instrValid) - CntWidth'(pop);
            instrCredit <= pop;  // Credit back to producer
        end
    end

    always_ff @(posedge clk) begin
        if (instrValid) queue[wrPtr] <= instr;
    end

    always_comb begin
        opDec      = OpZero;  // Unknown words fall through as no-ops
        rsDec      = '0;
        rtDec      = '0;
        destDec    = '0;
        useImmDec  = 1'b0;
        signExtDec = 1'b0;
        writeEnDec = 1'b0;
        if (head.rFmt.opcode == OpcR) begin
            case (head.rFmt.funct)
                FnAdd:   opDec = OpAdd;
                FnSub:   opDec = OpSub;
                FnAnd:   opDec = OpAnd;
                FnOr:    opDec = OpOr;
                FnXor:   opDec = OpXor;
                FnNor:   opDec = OpNor;
                FnSlt:   opDec = OpSlt;
                default: opDec = OpZero;
            endcase
            if (opDec != OpZero) begin
                rsDec      = head.rFmt.rs;
                rtDec      = head.rFmt.rt;
                destDec    = head.rFmt.rd;
                writeEnDec = 1'b1;
            end
        end else begin
            case (head.iFmt.opcode)
                OpcAddi: opDec = OpAdd;
                OpcSlti: opDec = OpSlt;
                OpcAndi: opDec = OpAnd;
                OpcOri:  opDec = OpOr;
                OpcXori: opDec = OpXor;
                default: opDec = OpZero;
            endcase
            if (opDec != OpZero) begin
                rsDec      = head.iFmt.rs;
                destDec    = head.iFmt.rt;                         // rt is the target
                useImmDec  = 1'b1;
                signExtDec = (opDec == OpAdd) || (opDec == OpSlt); // Logic forms zero-extend
                writeEnDec = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            decOut.valid <= 1'b0;
        end else if (!stall) begin
            decOut.valid <= pop;
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            decOut.aluOp   <= opDec;
            decOut.rs      <= rsDec;
            decOut.rt      <= rtDec;
            decOut.dest    <= destDec;
            decOut.imm     <= head.iFmt.imm;
            decOut.useImm  <= useImmDec;
            decOut.signExt <= signExtDec;
            decOut.writeEn <= writeEnDec;
        end
    end

    // Producer must hold a credit for every push
    noPushWhenFull: assert property (@(posedge clk) disable iff (!rstN)
        instrValid |-> (count != CntWidth'(InDepth)));

endmodule

`default_nettype wire

// File: rtl/operandStage.sv
// Register file and operand fetch
`timescale 1ns/10ps
`default_nettype none

module operandStage import aluPkg::*, isaPkg::*; (
    input  logic                    clk,
    input  logic                    rstN,
    input  logic                    stall,    // Pipeline hold from execute
    decIf.dst                       decIn,
    exIf.src                        exOut,
    input  logic                    wbEn,     // Item leaving execute writes
    input  logic [RegAddrWidth-1:0] wbDest,
    input  logic [DataWidth-1:0]    wbData
);

    localparam int NumRegs = 2 ** RegAddrWidth;

    logic [DataWidth-1:0] regs [NumRegs];  // Architectural registers
    logic                 fwdA;            // Bypass onto rs
    logic                 fwdB;            // Bypass onto rt
    logic [DataWidth-1:0] rsVal;
    logic [DataWidth-1:0] rtVal;
    logic [DataWidth-1:0] immExt;          // Extended immediate
    logic [DataWidth-1:0] opBSel;

    // Writes to register 0 are dropped, so it stays zero
    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < NumRegs; i++) begin
                regs[i] <= '0;
            end
        end else if (wbEn && (wbDest != '0)) begin
            regs[wbDest] <= wbData;
        end
    end

    // Only the item leaving execute this edge is not yet in the file
    assign fwdA = wbEn && (wbDest != '0) && (wbDest == decIn.rs);
    assign fwdB = wbEn && (wbDest != '0) && (wbDest == decIn.rt);

    assign rsVal = fwdA ? wbData : regs[decIn.rs];
    assign rtVal = fwdB ? wbData : regs[decIn.rt];

    // addi and slti sign-extend, logic immediates zero-extend
    assign immExt = decIn.signExt ? {{(DataWidth - 16){decIn.imm[15]}}, decIn.imm}
                                  : {{(DataWidth - 16){1'b0}}, decIn.imm};

    assign opBSel = decIn.useImm ? immExt : rtVal;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            exOut.valid <= 1'b0;
        end else if (!stall) begin
            exOut.valid <= decIn.valid;  // Bubble when decode is empty
        end
    end

    always_ff @(posedge clk) begin
        if (!stall && decIn.valid) begin
            exOut.aluOp   <= decIn.aluOp;
            exOut.opA     <= rsVal;
            exOut.opB     <= opBSel;
            exOut.dest    <= decIn.dest;
            exOut.writeEn <= decIn.writeEn;
        end
    end

endmodule

`default_nettype wire

// File: rtl/executeStage.sv
// Execute stage with output credits
`timescale 1ns/10ps
`default_nettype none

module executeStage import aluPkg::*, isaPkg::*; #(
    parameter int OutCredits = 2                    // Consumer's initial credits
) (
    input  logic                    clk,
    input  logic                    rstN,
    exIf.dst                        exIn,
    input  logic                    resultCredit,   // Consumer took a result
    output logic                    stall,          // Hold all stages
    output logic                    resultValid,
    output logic [DataWidth-1:0]    result,
    output logic                    resultZero,
    output logic [RegAddrWidth-1:0] resultDest,
    output logic                    wbEn,
    output logic [RegAddrWidth-1:0] wbDest,
    output logic [DataWidth-1:0]    wbData
);

    localparam int CntWidth = $clog2(OutCredits + 1);

    logic [CntWidth-1:0]  creditCnt;  // Credits still held
    logic                 accept;     // Item leaves on this edge
    logic [DataWidth-1:0] aluY;
    logic                 aluZero;

    alu aluInst (
        .aluOp (exIn.aluOp),
        .a     (exIn.opA),
        .b     (exIn.opB),
        .y     (aluY),
        .zero  (aluZero)
    );

    assign stall  = exIn.valid && (creditCnt == '0);  // Valid item, no credit
    assign accept = exIn.valid && !stall;

    // Register write lands on the same edge as resultValid
    assign wbEn   = accept && exIn.writeEn;
    assign wbDest = exIn.dest;
    assign wbData = aluY;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            creditCnt   <= CntWidth'(OutCredits);
            resultValid <= 1'b0;
        end else begin
            creditCnt   <= creditCnt - CntWidth'(accept) + CntWidth'(resultCredit);
            resultValid <= accept;  // One pulse per result
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            result     <= aluY;
            resultZero <= aluZero;
            resultDest <= exIn.dest;
        end
    end

    // Consumer never returns more than it was given
    creditBound: assert property (@(posedge clk) disable iff (!rstN)
        creditCnt <= CntWidth'(OutCredits));

    // Each result was backed by a credit
    resultHasCredit: assert property (@(posedge clk) disable iff (!rstN)
        resultValid |-> ($past(creditCnt) != '0));

endmodule

`default_nettype wire

// File: rtl/aluPipeTop.sv
// Execute pipeline top level
`timescale 1ns/10ps
`default_nettype none

module aluPipeTop import aluPkg::*, isaPkg::*; #(
    parameter int InDepth    = 4,  // Input queue depth
    parameter int OutCredits = 2   // Output credit count
) (
    input  logic                    clk,
    input  logic                    rstN,
    input  logic                    instrValid,    // Producer push
    input  logic [31:0]             instr,
    output logic                    instrCredit,   // Queue slot freed
    output logic                    resultValid,
    output logic [DataWidth-1:0]    result,
    output logic                    resultZero,
    output logic [RegAddrWidth-1:0] resultDest,
    input  logic                    resultCredit   // Consumer returns a credit
);

    logic                    stall;   // Shared pipeline hold
    logic                    wbEn;
    logic [RegAddrWidth-1:0] wbDest;
    logic [DataWidth-1:0]    wbData;

    decIf decBus ();
    exIf  exBus ();

    decodeStage #(.InDepth(InDepth)) decodeInst (
        .clk         (clk),
        .rstN        (rstN),
        .instrValid  (instrValid),
        .instr       (instr),
        .stall       (stall),
        .instrCredit (instrCredit),
        .decOut      (decBus.src)
    );

    operandStage operandInst (
        .clk    (clk),
        .rstN   (rstN),
        .stall  (stall),
        .decIn  (decBus.dst),
        .exOut  (exBus.src),
        .wbEn   (wbEn),
        .wbDest (wbDest),
        .wbData (wbData)
    );

    executeStage #(.OutCredits(OutCredits)) executeInst (
        .clk          (clk),
        .rstN         (rstN),
        .exIn         (exBus.dst),
        .resultCredit (resultCredit),
        .stall        (stall),
        .resultValid  (resultValid),
        .result       (result),
        .resultZero   (resultZero),
        .resultDest   (resultDest),
        .wbEn         (wbEn),
        .wbDest       (wbDest),
        .wbData       (wbData)
    );

endmodule

`default_nettype wire

// File: tb/clockGen.sv
// Testbench clock and reset
`timescale 1ns/10ps
`default_nettype none

module clockGen #(
    parameter int HalfPeriod  = 10,  // 20 ns period
    parameter int ResetCycles = 8    // Cycles held in reset
) (
    output logic clk,
    output logic rstN
);

    initial begin
        clk = 1'b0;
        forever #(HalfPeriod) clk = ~clk;
    end

    initial begin
        rstN = 1'b0;
        repeat (ResetCycles) @(posedge clk);
        rstN <= 1'b1;  // Release on a rising edge
    end

endmodule

`default_nettype wire

// File: tb/aluPipeTb.sv
// Execute pipeline testbench
`timescale 1ns/10ps
`default_nettype none

module aluPipeTb import aluPkg::*, isaPkg::*; ();

    localparam int InDepth       = 4;
    localparam int OutCredits    = 2;
    localparam int NumInstr      = 200;
    localparam int TimeoutCycles = NumInstr * 40;

    logic                    clk;
    logic                    rstN;
    logic                    instrValid;
    logic [31:0]             instr;
    logic                    instrCredit;
    logic                    resultValid;
    logic [DataWidth-1:0]    result;
    logic                    resultZero;
    logic [RegAddrWidth-1:0] resultDest;
    logic                    resultCredit;

    logic [31:0]             lfsrState = 32'hd3c5;  // Fixed seed
    logic [DataWidth-1:0]    modelRegs [32];        // Reference register file
    logic [DataWidth-1:0]    expData [$];           // Expected results in order
    logic [RegAddrWidth-1:0] expDest [$];
    logic                    expZero [$];
    instrT                   nextWord;
    int sentCount    = 0;
    int recvCount    = 0;
    int creditPulses = 0;           // instrCredit pulses seen
    int prodCredits  = InDepth;     // Producer's credits
    int pendingRet   = 0;           // Results taken, credit not yet returned
    int outstanding  = 0;           // Taken minus returned
    int dataErrors   = 0;
    int destErrors   = 0;
    int zeroErrors   = 0;
    int protoErrors  = 0;

    clockGen clkGen (.clk(clk), .rstN(rstN));

    aluPipeTop #(.InDepth(InDepth), .OutCredits(OutCredits)) UUT (
        .clk          (clk),
        .rstN         (rstN),
        .instrValid   (instrValid),
        .instr        (instr),
        .instrCredit  (instrCredit),
        .resultValid  (resultValid),
        .result       (result),
        .resultZero   (resultZero),
        .resultDest   (resultDest),
        .resultCredit (resultCredit)
    );

    // Galois LFSR, one step per bit
    function automatic logic [31:0] randBits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsrState = (lfsrState >> 1) ^ (lfsrState[0] ? 32'h80200003 : 32'h0);
            v = {v[30:0], lfsrState[0]};
        end
        return v;
    endfunction

    // Mostly r0..r3 so results feed each other
    function automatic logic [4:0] pickReg();
        if (randBits(2) != 0) return 5'(randBits(2));
        return 5'(randBits(5));
    endfunction

    function automatic instrT makeInstr();
        instrT w;
        logic [3:0] sel;
        sel = 4'(randBits(4));
        if (sel < 4'd7) begin                       // R-type
            w.rFmt.opcode = OpcR;
            w.rFmt.rs     = pickReg();
            w.rFmt.rt     = pickReg();
            w.rFmt.rd     = pickReg();
            w.rFmt.shamt  = 5'(randBits(5));
            case (randBits(3))
                0: w.rFmt.funct = FnAdd;
                1: w.rFmt.funct = FnSub;
                2: w.rFmt.funct = FnAnd;
                3: w.rFmt.funct = FnOr;
                4: w.rFmt.funct = FnXor;
                5: w.rFmt.funct = FnNor;
                6: w.rFmt.funct = FnSlt;
                default: w.rFmt.funct = 6'(randBits(6));  // Often unknown
            endcase
        end else if (sel < 4'd15) begin             // I-type
            case (randBits(3))
                0, 5: w.iFmt.opcode = OpcAddi;
                1, 6: w.iFmt.opcode = OpcSlti;
                2:    w.iFmt.opcode = OpcAndi;
                3:    w.iFmt.opcode = OpcOri;
                default: w.iFmt.opcode = OpcXori;
            endcase
            w.iFmt.rs  = pickReg();
            w.iFmt.rt  = pickReg();
            w.iFmt.imm = 16'(randBits(16));
        end else begin
            w = randBits(32);                       // Raw word, mostly no-op
        end
        return w;
    endfunction

    // Sign of A minus B
    function automatic logic [DataWidth-1:0] sltOf(input logic [DataWidth-1:0] a, b);
        logic [DataWidth-1:0] diff;
        diff = a - b;
        return {{(DataWidth - 1){1'b0}}, diff[DataWidth-1]};
    endfunction

    // Runs one word in program order and queues its expected result
    function automatic void modelExec(input instrT w);
        logic [DataWidth-1:0]    a;
        logic [DataWidth-1:0]    b;
        logic [DataWidth-1:0]    sx;
        logic [DataWidth-1:0]    zx;
        logic [DataWidth-1:0]    y;
        logic [RegAddrWidth-1:0] d;
        logic                    known;
        a     = modelRegs[w.rFmt.rs];
        b     = modelRegs[w.rFmt.rt];
        sx    = {{(DataWidth - 16){w.iFmt.imm[15]}}, w.iFmt.imm};
        zx    = {{(DataWidth - 16){1'b0}}, w.iFmt.imm};
        known = 1'b1;
        y     = '0;
        if (w.rFmt.opcode == OpcR) begin
            d = w.rFmt.rd;
            case (w.rFmt.funct)
                FnAdd:   y = a + b;
                FnSub:   y = a - b;
                FnAnd:   y = a & b;
                FnOr:    y = a | b;
                FnXor:   y = a ^ b;
                FnNor:   y = ~(a | b);
                FnSlt:   y = sltOf(a, b);
                default: known = 1'b0;
            endcase
        end else begin
            d = w.iFmt.rt;
            case (w.iFmt.opcode)
                OpcAddi: y = a + sx;
                OpcSlti: y = sltOf(a, sx);
                OpcAndi: y = a & zx;
                OpcOri:  y = a | zx;
                OpcXori: y = a ^ zx;
                default: known = 1'b0;
            endcase
        end
        if (!known) begin
            y = '0;  // No-op, value 0 to r0
            d = '0;
        end else if (d != '0) begin
            modelRegs[d] = y;
        end
        expData.push_back(y);
        expDest.push_back(d);
        expZero.push_back(y == '0);
    endfunction

    task automatic checkData(input logic [DataWidth-1:0] got, exp, input int idx);
        if (got !== exp) begin
            $display("FAIL %0t: result %0d value %h, expected %h", $time, idx, got, exp);
            dataErrors++;
        end
    endtask

    task automatic checkDest(input logic [RegAddrWidth-1:0] got, exp, input int idx);
        if (got !== exp) begin
            $display("FAIL %0t: result %0d dest %0d, expected %0d", $time, idx, got, exp);
            destErrors++;
        end
    endtask

    task automatic checkZero(input logic got, exp, input int idx);
        if (got !== exp) begin
            $display("FAIL %0t: result %0d zero %b, expected %b", $time, idx, got, exp);
            zeroErrors++;
        end
    endtask

    initial begin
        instrValid   = 1'b0;
        instr        = '0;
        resultCredit = 1'b0;
        for (int i = 0; i < 32; i++) begin
            modelRegs[i] = '0;
        end
    end

    // Producer and consumer share one process so the LFSR order is fixed
    always @(posedge clk) begin
        instrValid   <= 1'b0;
        resultCredit <= 1'b0;
        if (rstN) begin
            if (instrCredit) begin
                creditPulses++;
                prodCredits++;
                if (prodCredits > InDepth) begin
                    $display("Producer got more credits back than the queue holds");
                    protoErrors++;
                end
            end
            if (sentCount < NumInstr && prodCredits > 0 && randBits(2) != 0) begin
                nextWord = makeInstr();
                modelExec(nextWord);
                instr       <= nextWord;
                instrValid  <= 1'b1;
                prodCredits--;
                sentCount++;
            end
            if (resultValid) begin
                if (expData.size() == 0) begin
                    $display("A result arrived with none outstanding");
                    protoErrors++;
                end else begin
                    checkData(result, expData.pop_front(), recvCount);
                    checkDest(resultDest, expDest.pop_front(), recvCount);
                    checkZero(resultZero, expZero.pop_front(), recvCount);
                end
                recvCount++;
                pendingRet++;
                outstanding++;
                if (outstanding > OutCredits) begin
                    $display("More results outstanding than output credits allow");
                    protoErrors++;
                end
            end
            if (pendingRet > 0 && randBits(1) != 0) begin  // Random return delay
                resultCredit <= 1'b1;
                pendingRet--;
                outstanding--;
            end
        end
    end

    initial begin
        wait (rstN === 1'b1);
        wait (recvCount == NumInstr);
        repeat (4) @(posedge clk);      // Catch stray results and credit pulses
        if (creditPulses != sentCount) begin
            $display("Saw %0d instrCredit pulses for %0d words sent", creditPulses, sentCount);
            protoErrors++;
        end
        $display("Errors: data %0d, dest %0d, zero %0d, protocol %0d",
                 dataErrors, destErrors, zeroErrors, protoErrors);
        if (dataErrors + destErrors + zeroErrors + protoErrors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    // Watchdog
    initial begin
        repeat (TimeoutCycles) @(posedge clk);
        $display("Timed out with %0d of %0d results received", recvCount, NumInstr);
        $display("*** FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

// File: src.f
common/aluPkg.sv
common/isaPkg.sv
common/pipeIfs.sv
alu/alu.sv
rtl/decodeStage.sv
rtl/operandStage.sv
rtl/executeStage.sv
rtl/aluPipeTop.sv
tb/clockGen.sv
tb/aluPipeTb.sv
